//--- all.f
+incdir+src
src/csr_map_pkg.sv
src/csr_bus_pkg.sv
src/csr_apb_decode.sv
src/csr_ctrl_trigger.sv
src/csr_irq_status.sv
src/csr_cmd_regs.sv
src/qspi_csr_top.sv
test/tb_qspi_csr_checks.sv
test/tb_qspi_csr.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_qspi_csr -f all.f -o sim_qspi_csr > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_qspi_csr > sim.log 2>&1
cat sim.log

grep -qx "Everything OK" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

//--- test/tb_qspi_csr.sv
/*
  Testbench for the QSPI APB register block.
  Drives APB and the engine inputs; the checker instance does all value checks.
  Watchdog bound scales with the number of planned transfers.
*/
`include "qspi_csr_config.svh"

module tb_qspi_csr;
  timeunit 1ns;
  timeprecision 100ps;
  import csr_map_pkg::*;
  import csr_bus_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int MAX_XFERS   = 160;
  localparam int XFER_CYCLES = 6;
  localparam int WAIT_LIMIT  = 16;
  localparam int TIMEOUT_NS  = (MAX_XFERS * XFER_CYCLES + 200) * CLK_PERIOD;

  logic                   pclk;
  logic                   presetn;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`CSR_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  ctrl_bus_t              ctrl_o;
  cmd_cfg_bus_t           cmd_cfg_o;
  logic                   cmd_start_o;
  logic                   cmd_trigger_clr_i;
  logic                   busy_i;
  csr_events_t            events_i;
  logic                   irq_o;
  logic [2:0]             test_id;
  int                     seed;
  int                     xfers;
  int                     tb_faults;
  int                     mismatches;
  int                     faults;

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  qspi_csr_top DUT (
    .pclk              (pclk),
    .presetn           (presetn),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .pready            (pready),
    .pslverr           (pslverr),
    .ctrl_o            (ctrl_o),
    .cmd_cfg_o         (cmd_cfg_o),
    .cmd_start_o       (cmd_start_o),
    .cmd_trigger_clr_i (cmd_trigger_clr_i),
    .busy_i            (busy_i),
    .events_i          (events_i),
    .irq_o             (irq_o)
  );

  tb_qspi_csr_checks u_checks (
    .pclk              (pclk),
    .presetn           (presetn),
    .test_id_i         (test_id),
    .psel_i            (psel),
    .penable_i         (penable),
    .pwrite_i          (pwrite),
    .paddr_i           (paddr),
    .pwdata_i          (pwdata),
    .prdata_i          (prdata),
    .pready_i          (pready),
    .pslverr_i         (pslverr),
    .ctrl_i            (ctrl_o),
    .cmd_cfg_i         (cmd_cfg_o),
    .cmd_start_i       (cmd_start_o),
    .cmd_trigger_clr_i (cmd_trigger_clr_i),
    .busy_i            (busy_i),
    .events_i          (events_i),
    .irq_i             (irq_o),
    .mismatches_o      (mismatches),
    .faults_o          (faults)
  );

  // ----------------------------------------
  // APB and engine side tasks
  task automatic apb_transfer(input logic write, input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk);
    penable <= 1'b1;
    // Access phase ends on the first edge with pready high
    do begin
      @(posedge pclk);
    end while (!pready);
    psel    <= 1'b0;
    penable <= 1'b0;
    xfers++;
  endtask

  task automatic apb_write(input logic [`CSR_ADDR_W-1:0] addr, input logic [31:0] data);
    apb_transfer(1'b1, addr, data);
  endtask

  task automatic apb_read(input logic [`CSR_ADDR_W-1:0] addr);
    apb_transfer(1'b0, addr, 32'h0);
  endtask

  task automatic write_read_random(input logic [`CSR_ADDR_W-1:0] addr);
    logic [31:0] data;
    data = $random(seed);
    apb_write(addr, data);
    apb_read(addr);
  endtask

  task automatic pulse_clear();
    @(posedge pclk);
    cmd_trigger_clr_i <= 1'b1;
    @(posedge pclk);
    cmd_trigger_clr_i <= 1'b0;
  endtask

  task automatic pulse_events(input logic done, input logic err);
    @(posedge pclk);
    events_i.cmd_done_set <= done;
    events_i.err_set      <= err;
    @(posedge pclk);
    events_i.cmd_done_set <= 1'b0;
    events_i.err_set      <= 1'b0;
  endtask

  task automatic set_busy(input logic level);
    @(posedge pclk);
    busy_i <= level;
  endtask

  task automatic wait_start(input logic level, input string what);
    int n;
    n = 0;
    while ((cmd_start_o != level) && (n < WAIT_LIMIT)) begin
      @(posedge pclk);
      n++;
    end
    if (cmd_start_o != level) begin
      tb_faults++;
      $display("cmd_start_o did not %s within %0d cycles", what, WAIT_LIMIT);
    end
  endtask

  // ----------------------------------------
  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns with %0d transfers done", TIMEOUT_NS, xfers);
    $display("Something failed");
    $finish;
  end

  initial begin
    seed              = 32'h908334fe;
    xfers             = 0;
    tb_faults         = 0;
    test_id           = 3'd0;
    pclk              = 1'b0;
    presetn           = 1'b0;
    psel              = 1'b0;
    penable           = 1'b0;
    pwrite            = 1'b0;
    paddr             = '0;
    pwdata            = 32'h0;
    cmd_trigger_clr_i = 1'b0;
    busy_i            = 1'b0;
    events_i          = '0;
    repeat (3) @(posedge pclk);
    presetn <= 1'b1;

    // Reset values and ID
    test_id <= 3'd1;
    apb_read(OFF_ID);
    apb_read(OFF_CTRL);
    apb_read(OFF_STATUS);
    apb_read(OFF_INT_EN);
    apb_read(OFF_INT_STAT);
    apb_read(OFF_CMD_CFG);
    apb_read(OFF_CMD_OP);
    apb_read(OFF_CMD_ADDR);
    apb_read(OFF_CMD_LEN);

    // Random data against the write masks
    test_id <= 3'd2;
    for (int i = 0; i < 8; i++) begin
      write_read_random(OFF_CTRL);
      write_read_random(OFF_CMD_CFG);
      write_read_random(OFF_CMD_OP);
      write_read_random(OFF_CMD_ADDR);
      write_read_random(OFF_CMD_LEN);
    end

    // Unmapped and read-only accesses
    test_id <= 3'd3;
    apb_read(12'h100);
    apb_read(12'h006);
    apb_write(12'h040, 32'hDEAD_BEEF);
    apb_write(OFF_ID, 32'hFFFF_FFFF);
    apb_write(OFF_STATUS, 32'h0);
    apb_read(OFF_ID);

    // Trigger handshake and its gating
    test_id <= 3'd4;
    pulse_clear();
    apb_write(OFF_CTRL, 32'h0000_0001);
    apb_write(OFF_CTRL, 32'h0000_0101);
    wait_start(1'b1, "rise");
    pulse_clear();
    wait_start(1'b0, "fall");
    apb_write(OFF_CTRL, 32'h0000_0000);
    apb_write(OFF_CTRL, 32'h0000_0100);
    apb_write(OFF_CTRL, 32'h0000_0003);
    apb_write(OFF_CTRL, 32'h0000_0103);
    apb_write(OFF_CTRL, 32'h0000_0001);
    set_busy(1'b1);
    apb_write(OFF_CTRL, 32'h0000_0103);
    apb_read(OFF_CTRL);
    apb_read(OFF_STATUS);
    set_busy(1'b0);
    apb_read(OFF_CTRL);

    // Interrupt sources, enables and clears
    test_id <= 3'd5;
    apb_write(OFF_INT_EN, 32'h0);
    apb_write(OFF_INT_STAT, 32'h3);
    apb_write(OFF_STATUS, 32'h1);
    pulse_events(1'b1, 1'b0);
    apb_read(OFF_INT_STAT);
    apb_read(OFF_STATUS);
    apb_write(OFF_INT_EN, 32'h1);
    pulse_events(1'b0, 1'b1);
    apb_read(OFF_INT_STAT);
    apb_write(OFF_INT_EN, 32'h2);
    apb_write(OFF_INT_STAT, 32'h2);
    apb_write(OFF_INT_STAT, 32'h1);
    apb_write(OFF_STATUS, 32'h1);
    apb_read(OFF_STATUS);
    apb_read(OFF_INT_STAT);
    apb_read(OFF_INT_EN);

    test_id <= 3'd0;
    repeat (4) @(posedge pclk);
    $display("Transfers %0d, mismatches %0d, other errors %0d",
             xfers, mismatches, faults + tb_faults);
    if ((mismatches + faults + tb_faults) == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- test/tb_qspi_csr_checks.sv
/*
  Reference model and concurrent checks for the QSPI register block.
  Shadow state follows the APB traffic and engine inputs seen at each rising edge.
  Error counts go back to the testbench top for the final report.
*/
`include "qspi_csr_config.svh"

module tb_qspi_csr_checks (
  input  logic                      pclk,
  input  logic                      presetn,
  input  logic [2:0]                test_id_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [`CSR_ADDR_W-1:0]    paddr_i,
  input  logic [31:0]               pwdata_i,
  input  logic [31:0]               prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i,
  input  csr_bus_pkg::ctrl_bus_t    ctrl_i,
  input  csr_bus_pkg::cmd_cfg_bus_t cmd_cfg_i,
  input  logic                      cmd_start_i,
  input  logic                      cmd_trigger_clr_i,
  input  logic                      busy_i,
  input  csr_bus_pkg::csr_events_t  events_i,
  input  logic                      irq_i,
  output int                        mismatches_o,
  output int                        faults_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import csr_map_pkg::*;
  import csr_bus_pkg::*;

  logic         hit_id;
  logic         hit_ctrl;
  logic         hit_status;
  logic         hit_int_en;
  logic         hit_int_stat;
  logic         hit_cmd_cfg;
  logic         hit_cmd_op;
  logic         hit_cmd_addr;
  logic         hit_cmd_len;
  logic         mapped;
  logic         access;
  logic         wr_acc;
  logic         trig_wr;
  logic         trig_ok;
  logic [31:0]  sh_ctrl;
  logic [31:0]  ctrl_next;
  logic [31:0]  sh_cfg;
  logic [15:0]  sh_op;
  logic [31:0]  sh_addr;
  logic [31:0]  sh_len;
  logic [1:0]   sh_en;
  logic [1:0]   sh_stat;
  logic [1:0]   stat_clr;
  logic         sh_done;
  logic         sh_start;
  logic [31:0]  exp_rdata;
  logic         exp_pslverr;
  logic         exp_irq;
  ctrl_bus_t    exp_ctrl;
  cmd_cfg_bus_t exp_cfg;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "reset_id";
      3'd2:    return "masked_readback";
      3'd3:    return "errors";
      3'd4:    return "trigger";
      3'd5:    return "interrupts";
      default: return "idle";
    endcase
  endfunction

  initial begin
    mismatches_o = 0;
    faults_o     = 0;
  end

  // ----------------------------------------
  // Own address decode of the register map
  assign hit_id       = (paddr_i == OFF_ID);
  assign hit_ctrl     = (paddr_i == OFF_CTRL);
  assign hit_status   = (paddr_i == OFF_STATUS);
  assign hit_int_en   = (paddr_i == OFF_INT_EN);
  assign hit_int_stat = (paddr_i == OFF_INT_STAT);
  assign hit_cmd_cfg  = (paddr_i == OFF_CMD_CFG);
  assign hit_cmd_op   = (paddr_i == OFF_CMD_OP);
  assign hit_cmd_addr = (paddr_i == OFF_CMD_ADDR);
  assign hit_cmd_len  = (paddr_i == OFF_CMD_LEN);
  assign mapped = hit_id | hit_ctrl | hit_status | hit_int_en | hit_int_stat |
                  hit_cmd_cfg | hit_cmd_op | hit_cmd_addr | hit_cmd_len;

  assign access  = psel_i && penable_i;
  // STATUS writes still clear the done latch
  assign wr_acc  = access && pwrite_i && mapped && !hit_id;
  assign trig_wr = wr_acc && hit_ctrl && pwdata_i[8];
  assign trig_ok = trig_wr && sh_ctrl[0] && !sh_ctrl[1] && !busy_i;
  assign stat_clr = (wr_acc && hit_int_stat) ? pwdata_i[1:0] : 2'b00;

  always_comb begin
    ctrl_next = pwdata_i & `CSR_CTRL_WMASK;
    // xip_en holds while a command runs
    if (busy_i) begin
      ctrl_next[1] = sh_ctrl[1];
    end
  end

  // ----------------------------------------
  // Shadow register state
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      sh_ctrl  <= 32'h0;
      sh_cfg   <= 32'h0;
      sh_op    <= 16'h0;
      sh_addr  <= 32'h0;
      sh_len   <= 32'h0;
      sh_en    <= 2'b00;
      sh_stat  <= 2'b00;
      sh_done  <= 1'b0;
      sh_start <= 1'b0;
    end else begin
      if (wr_acc && hit_ctrl) begin
        sh_ctrl <= ctrl_next;
      end
      if (wr_acc && hit_cmd_cfg) begin
        sh_cfg <= pwdata_i & `CSR_CMD_CFG_WMASK;
      end
      if (wr_acc && hit_cmd_op) begin
        sh_op <= pwdata_i[15:0];
      end
      if (wr_acc && hit_cmd_addr) begin
        sh_addr <= pwdata_i;
      end
      if (wr_acc && hit_cmd_len) begin
        sh_len <= pwdata_i;
      end
      if (wr_acc && hit_int_en) begin
        sh_en <= pwdata_i[1:0];
      end
      sh_stat <= (sh_stat & ~stat_clr) | {events_i.err_set, events_i.cmd_done_set};
      if (events_i.cmd_done_set) begin
        sh_done <= 1'b1;
      end else if (wr_acc && hit_status && pwdata_i[0]) begin
        sh_done <= 1'b0;
      end
      if (cmd_trigger_clr_i) begin
        sh_start <= 1'b0;
      end else if (trig_ok) begin
        sh_start <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Expected outputs
  always_comb begin
    exp_rdata = 32'h0;
    if (hit_id) begin
      exp_rdata = `CSR_ID_VALUE;
    end else if (hit_ctrl) begin
      exp_rdata = sh_ctrl;
    end else if (hit_status) begin
      exp_rdata = {30'h0, busy_i, sh_done};
    end else if (hit_int_en) begin
      exp_rdata = {30'h0, sh_en};
    end else if (hit_int_stat) begin
      exp_rdata = {30'h0, sh_stat};
    end else if (hit_cmd_cfg) begin
      exp_rdata = sh_cfg;
    end else if (hit_cmd_op) begin
      exp_rdata = {16'h0, sh_op};
    end else if (hit_cmd_addr) begin
      exp_rdata = sh_addr;
    end else if (hit_cmd_len) begin
      exp_rdata = sh_len;
    end
  end

  assign exp_pslverr = access && (!mapped || (pwrite_i && (hit_id || hit_status)) ||
                                  (trig_wr && busy_i));
  assign exp_irq = |(sh_en & sh_stat);

  always_comb begin
    exp_ctrl.enable     = sh_ctrl[0];
    exp_ctrl.xip_en     = sh_ctrl[1];
    exp_ctrl.quad_en    = sh_ctrl[2];
    exp_ctrl.cpol       = sh_ctrl[3];
    exp_ctrl.cpha       = sh_ctrl[4];
    exp_ctrl.lsb_first  = sh_ctrl[5];
    exp_cfg.cmd_lanes   = sh_cfg[1:0];
    exp_cfg.addr_lanes  = sh_cfg[3:2];
    exp_cfg.data_lanes  = sh_cfg[5:4];
    exp_cfg.addr_bytes  = sh_cfg[7:6];
    exp_cfg.dummy       = sh_cfg[11:8];
    exp_cfg.is_write    = sh_cfg[12];
    exp_cfg.mode_en     = sh_cfg[13];
    exp_cfg.opcode      = sh_op[7:0];
    exp_cfg.mode_bits   = sh_op[15:8];
    exp_cfg.address     = sh_addr;
    exp_cfg.length      = sh_len;
  end

  // ----------------------------------------
  // Checks
  a_read_data: assert property (@(posedge pclk) disable iff (!presetn)
    (psel_i && penable_i && !pwrite_i) |-> (prdata_i == exp_rdata))
    else begin
      mismatches_o++;
      $display("Mismatch in %s: prdata at offset 0x%h expected 0x%h, actual 0x%h",
               test_name(test_id_i), $sampled(paddr_i), $sampled(exp_rdata),
               $sampled(prdata_i));
    end

  a_pslverr: assert property (@(posedge pclk) disable iff (!presetn)
    pslverr_i == exp_pslverr)
    else begin
      mismatches_o++;
      $display("Mismatch in %s: pslverr at offset 0x%h expected %b, actual %b",
               test_name(test_id_i), $sampled(paddr_i), $sampled(exp_pslverr),
               $sampled(pslverr_i));
    end

  a_pready: assert property (@(posedge pclk) disable iff (!presetn)
    (psel_i && penable_i) |-> pready_i)
    else begin
      faults_o++;
      $display("In %s pready was low during an access phase", test_name(test_id_i));
    end

  a_start: assert property (@(posedge pclk) disable iff (!presetn)
    cmd_start_i == sh_start)
    else begin
      mismatches_o++;
      $display("Mismatch in %s: cmd_start_o expected %b, actual %b",
               test_name(test_id_i), $sampled(sh_start), $sampled(cmd_start_i));
    end

  a_irq: assert property (@(posedge pclk) disable iff (!presetn)
    irq_i == exp_irq)
    else begin
      mismatches_o++;
      $display("Mismatch in %s: irq_o expected %b, actual %b",
               test_name(test_id_i), $sampled(exp_irq), $sampled(irq_i));
    end

  a_ctrl_out: assert property (@(posedge pclk) disable iff (!presetn)
    ctrl_i == exp_ctrl)
    else begin
      mismatches_o++;
      $display("Mismatch in %s: ctrl_o expected 0x%h, actual 0x%h",
               test_name(test_id_i), $sampled(exp_ctrl), $sampled(ctrl_i));
    end

  a_cmd_cfg_out: assert property (@(posedge pclk) disable iff (!presetn)
    cmd_cfg_i == exp_cfg)
    else begin
      mismatches_o++;
      $display("Mismatch in %s: cmd_cfg_o expected 0x%h, actual 0x%h",
               test_name(test_id_i), $sampled(exp_cfg), $sampled(cmd_cfg_i));
    end

endmodule

//--- src/qspi_csr_top.sv
/*
  APB register block of the QSPI flash controller.
  Zero wait states, full-word writes only, PSLVERR on bad or locked-out access.
*/
`include "qspi_csr_config.svh"

module qspi_csr_top (
  input  logic                      pclk,
  input  logic                      presetn,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`CSR_ADDR_W-1:0]    paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output csr_bus_pkg::ctrl_bus_t    ctrl_o,
  output csr_bus_pkg::cmd_cfg_bus_t cmd_cfg_o,
  output logic                      cmd_start_o,
  input  logic                      cmd_trigger_clr_i,
  input  logic                      busy_i,
  input  csr_bus_pkg::csr_events_t  events_i,
  output logic                      irq_o
);
  import csr_bus_pkg::*;

  csr_wr_t     wr;
  csr_rd_t     rd;
  logic        lockout;
  logic [31:0] ctrl_rdata;
  logic [31:0] irq_rdata;
  logic [31:0] cmd_rdata;

  csr_apb_decode u_decode (
    .pclk         (pclk),
    .presetn      (presetn),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .lockout_i    (lockout),
    .ctrl_rdata_i (ctrl_rdata),
    .irq_rdata_i  (irq_rdata),
    .cmd_rdata_i  (cmd_rdata),
    .wr_o         (wr),
    .rd_o         (rd),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  csr_ctrl_trigger u_ctrl (
    .pclk              (pclk),
    .presetn           (presetn),
    .wr_i              (wr),
    .rd_i              (rd),
    .busy_i            (busy_i),
    .cmd_trigger_clr_i (cmd_trigger_clr_i),
    .ctrl_o            (ctrl_o),
    .cmd_start_o       (cmd_start_o),
    .lockout_o         (lockout),
    .rdata_o           (ctrl_rdata)
  );

  csr_irq_status u_irq (
    .pclk     (pclk),
    .presetn  (presetn),
    .wr_i     (wr),
    .rd_i     (rd),
    .events_i (events_i),
    .busy_i   (busy_i),
    .irq_o    (irq_o),
    .rdata_o  (irq_rdata)
  );

  csr_cmd_regs u_cmd (
    .pclk      (pclk),
    .presetn   (presetn),
    .wr_i      (wr),
    .rd_i      (rd),
    .cmd_cfg_o (cmd_cfg_o),
    .rdata_o   (cmd_rdata)
  );

endmodule

//--- src/csr_cmd_regs.sv
/*
  Command setup registers CMD_CFG, CMD_OP, CMD_ADDR and CMD_LEN.
  CMD_CFG keeps bits 13:0 and CMD_OP bits 15:0; unused bits read zero.
*/
`include "qspi_csr_config.svh"

module csr_cmd_regs (
  input  logic                      pclk,
  input  logic                      presetn,
  input  csr_bus_pkg::csr_wr_t      wr_i,
  input  csr_bus_pkg::csr_rd_t      rd_i,
  output csr_bus_pkg::cmd_cfg_bus_t cmd_cfg_o,
  output logic [31:0]               rdata_o
);
  import csr_map_pkg::*;

  cmd_cfg_t    cfg_q;
  logic [15:0] op_q;
  logic [31:0] addr_q;
  logic [31:0] len_q;

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      cfg_q  <= cmd_cfg_t'(`CSR_CMD_RESET);
      op_q   <= 16'h0;
      addr_q <= `CSR_CMD_RESET;
      len_q  <= `CSR_CMD_RESET;
    end else if (wr_i.valid) begin
      case (wr_i.idx)
        REG_CMD_CFG:  cfg_q  <= cmd_cfg_t'(wr_i.data & `CSR_CMD_CFG_WMASK);
        REG_CMD_OP:   op_q   <= wr_i.data[15:0];
        REG_CMD_ADDR: addr_q <= wr_i.data;
        REG_CMD_LEN:  len_q  <= wr_i.data;
        default:      ;
      endcase
    end
  end

  // ----------------------------------------
  // Readback
  always_comb begin
    rdata_o = 32'h0;
    if (rd_i.valid) begin
      case (rd_i.idx)
        REG_CMD_CFG:  rdata_o = cfg_q;
        REG_CMD_OP:   rdata_o = {16'h0, op_q};
        REG_CMD_ADDR: rdata_o = addr_q;
        REG_CMD_LEN:  rdata_o = len_q;
        default:      rdata_o = 32'h0;
      endcase
    end
  end

  // Fields for the command engine
  assign cmd_cfg_o.cmd_lanes  = cfg_q.cmd_lanes;
  assign cmd_cfg_o.addr_lanes = cfg_q.addr_lanes;
  assign cmd_cfg_o.data_lanes = cfg_q.data_lanes;
  assign cmd_cfg_o.addr_bytes = cfg_q.addr_bytes;
  assign cmd_cfg_o.dummy      = cfg_q.dummy_cycles;
  assign cmd_cfg_o.is_write   = cfg_q.is_write;
  assign cmd_cfg_o.mode_en    = cfg_q.mode_en;
  assign cmd_cfg_o.opcode     = op_q[7:0];
  assign cmd_cfg_o.mode_bits  = op_q[15:8];
  assign cmd_cfg_o.address    = addr_q;
  assign cmd_cfg_o.length     = len_q;

endmodule

//--- src/csr_irq_status.sv
/*
  INT_EN, write-one-to-clear INT_STAT, the STATUS cmd_done latch and irq.
  An event in the same cycle as a clear leaves its bit set.
  STATUS reads busy in bit 1 and the cmd_done latch in bit 0.
*/
`include "qspi_csr_config.svh"

module csr_irq_status (
  input  logic                     pclk,
  input  logic                     presetn,
  input  csr_bus_pkg::csr_wr_t     wr_i,
  input  csr_bus_pkg::csr_rd_t     rd_i,
  input  csr_bus_pkg::csr_events_t events_i,
  input  logic                     busy_i,
  output logic                     irq_o,
  output logic [31:0]              rdata_o
);
  import csr_map_pkg::*;

  irq_vec_t int_en_q;
  irq_vec_t int_stat_q;
  irq_vec_t stat_set;
  irq_vec_t stat_clr;
  logic     done_q;
  logic     en_wr;
  logic     stat_wr;
  logic     status_wr;

  assign en_wr     = wr_i.valid && (wr_i.idx == REG_INT_EN);
  assign stat_wr   = wr_i.valid && (wr_i.idx == REG_INT_STAT);
  assign status_wr = wr_i.valid && (wr_i.idx == REG_STATUS);

  assign stat_set.cmd_done = events_i.cmd_done_set;
  assign stat_set.err      = events_i.err_set;
  assign stat_clr = stat_wr ? irq_vec_t'(wr_i.data[1:0]) : irq_vec_t'(2'b00);

  // ----------------------------------------
  // Enable, status and latch
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      int_en_q   <= irq_vec_t'(`CSR_INT_RESET);
      int_stat_q <= irq_vec_t'(`CSR_INT_RESET);
      done_q     <= 1'b0;
    end else begin
      if (en_wr) begin
        int_en_q <= irq_vec_t'(wr_i.data[1:0]);
      end
      int_stat_q <= irq_vec_t'((int_stat_q & ~stat_clr) | stat_set);
      if (events_i.cmd_done_set) begin
        done_q <= 1'b1;
      end else if (status_wr && wr_i.data[0]) begin
        done_q <= 1'b0;
      end
    end
  end

  assign irq_o = |(int_en_q & int_stat_q);

  // ----------------------------------------
  // Readback
  always_comb begin
    rdata_o = 32'h0;
    if (rd_i.valid) begin
      case (rd_i.idx)
        REG_STATUS:   rdata_o = {30'h0, busy_i, done_q};
        REG_INT_EN:   rdata_o = {30'h0, int_en_q};
        REG_INT_STAT: rdata_o = {30'h0, int_stat_q};
        default:      rdata_o = 32'h0;
      endcase
    end
  end

  // irq only rises after an engine event or an INT_EN write
  a_irq_cause: assert property (
    @(posedge pclk) disable iff (!presetn)
    $rose(irq_o) |-> $past(events_i.cmd_done_set || events_i.err_set || en_wr)
  );

endmodule

//--- src/csr_ctrl_trigger.sv
/*
  CTRL register and the write-one-to-start command trigger.
  Trigger is accepted only with enable set, xip_en clear and busy low.
  cmd_start_o holds until the engine returns cmd_trigger_clr_i.
*/
`include "qspi_csr_config.svh"

module csr_ctrl_trigger (
  input  logic                    pclk,
  input  logic                    presetn,
  input  csr_bus_pkg::csr_wr_t    wr_i,
  input  csr_bus_pkg::csr_rd_t    rd_i,
  input  logic                    busy_i,
  input  logic                    cmd_trigger_clr_i,
  output csr_bus_pkg::ctrl_bus_t  ctrl_o,
  output logic                    cmd_start_o,
  output logic                    lockout_o,
  output logic [31:0]             rdata_o
);
  import csr_map_pkg::*;

  ctrl_reg_t ctrl_q;
  ctrl_reg_t ctrl_next;
  ctrl_reg_t wr_word;
  logic      ctrl_wr;
  logic      trig_wr;
  logic      trig_ok;
  logic      start_q;

  assign wr_word = ctrl_reg_t'(wr_i.data);
  assign ctrl_wr = wr_i.valid && (wr_i.idx == REG_CTRL);
  assign trig_wr = ctrl_wr && wr_word.trigger;

  // Gate on the value held before this write
  assign trig_ok   = trig_wr && ctrl_q.enable && !ctrl_q.xip_en && !busy_i;
  assign lockout_o = trig_wr && busy_i;

  // ----------------------------------------
  // Next CTRL value
  always_comb begin
    ctrl_next = ctrl_reg_t'(wr_i.data & `CSR_CTRL_WMASK);
    // xip_en cannot change under a running command
    if (busy_i) begin
      ctrl_next.xip_en = ctrl_q.xip_en;
    end
  end

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      ctrl_q  <= ctrl_reg_t'(`CSR_CTRL_RESET);
      start_q <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        ctrl_q <= ctrl_next;
      end
      // Clear wins over a new trigger
      if (cmd_trigger_clr_i) begin
        start_q <= 1'b0;
      end else if (trig_ok) begin
        start_q <= 1'b1;
      end
    end
  end

  assign cmd_start_o = start_q;

  assign ctrl_o.enable    = ctrl_q.enable;
  assign ctrl_o.xip_en    = ctrl_q.xip_en;
  assign ctrl_o.quad_en   = ctrl_q.quad_en;
  assign ctrl_o.cpol      = ctrl_q.cpol;
  assign ctrl_o.cpha      = ctrl_q.cpha;
  assign ctrl_o.lsb_first = ctrl_q.lsb_first;

  assign rdata_o = (rd_i.valid && (rd_i.idx == REG_CTRL)) ? ctrl_q : 32'h0;

  // A start only follows a cycle in which XIP was off
  a_no_start_in_xip: assert property (
    @(posedge pclk) disable iff (!presetn)
    $rose(cmd_start_o) |-> !$past(ctrl_q.xip_en)
  );

endmodule

//--- src/csr_apb_decode.sv
/*
  Zero-wait-state APB front end. PREADY is tied high and PRDATA is combinational.
  PSTRB is not supported; every write is a full word.
  Writes to STATUS report PSLVERR but still pass their W1C side effect on.
*/
`include "qspi_csr_config.svh"

module csr_apb_decode (
  input  logic                   pclk,
  input  logic                   presetn,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`CSR_ADDR_W-1:0] paddr,
  input  logic [31:0]            pwdata,
  input  logic                   lockout_i,
  input  logic [31:0]            ctrl_rdata_i,
  input  logic [31:0]            irq_rdata_i,
  input  logic [31:0]            cmd_rdata_i,
  output csr_bus_pkg::csr_wr_t   wr_o,
  output csr_bus_pkg::csr_rd_t   rd_o,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);
  import csr_map_pkg::*;

  logic     access_phase;
  logic     write_phase;
  logic     read_phase;
  csr_reg_e reg_idx;
  logic     mapped;
  logic     read_only;
  logic     wr_ok;
  logic     rd_ok;
  logic [31:0] id_rdata;

  // ----------------------------------------
  // Phase detection
  assign access_phase = psel && penable;
  assign write_phase  = access_phase && pwrite;
  assign read_phase   = access_phase && !pwrite;
  assign pready       = 1'b1;

  // ----------------------------------------
  // Address decode
  assign reg_idx   = csr_lookup(paddr);
  assign mapped    = (reg_idx != REG_NONE);
  assign read_only = csr_is_ro(reg_idx);

  // ID has no storage, so its writes go nowhere
  assign wr_ok = write_phase && mapped && (reg_idx != REG_ID);
  assign rd_ok = read_phase && mapped;

  assign wr_o.valid = wr_ok;
  assign wr_o.idx   = reg_idx;
  assign wr_o.data  = pwdata;

  assign rd_o.valid = rd_ok;
  assign rd_o.idx   = reg_idx;

  // ----------------------------------------
  // Error response
  always_comb begin
    pslverr = 1'b0;
    if (access_phase) begin
      if (!mapped) begin
        pslverr = 1'b1;
      end else if (pwrite && read_only) begin
        pslverr = 1'b1;
      end else if (lockout_i) begin
        // Trigger while busy as flagged by the CTRL block
        pslverr = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Read data merge over blocks that return zero when not selected
  assign id_rdata = (rd_ok && (reg_idx == REG_ID)) ? `CSR_ID_VALUE : 32'h0;

  always_comb begin
    prdata = 32'h0;
    if (read_phase) begin
      prdata = id_rdata | ctrl_rdata_i | irq_rdata_i | cmd_rdata_i;
    end
  end

  // Lockout from the CTRL block only comes with a CTRL write in its access phase
  a_lockout_ctrl_write: assert property (
    @(posedge pclk) disable iff (!presetn)
    lockout_i |-> (write_phase && (reg_idx == REG_CTRL))
  );

endmodule

//--- src/csr_bus_pkg.sv
/*
  Bundles passed between the decoder, the register blocks and the command engine.
  All bundles are single-cycle qualified by their valid bit where one exists.
*/
package csr_bus_pkg;

  // Write accepted by decode, broadcast to all register blocks
  typedef struct packed {
    logic                  valid;
    csr_map_pkg::csr_reg_e idx;
    logic [31:0]           data;
  } csr_wr_t;

  // Read selection during the access phase
  typedef struct packed {
    logic                  valid;
    csr_map_pkg::csr_reg_e idx;
  } csr_rd_t;

  // Command setup seen by the engine
  typedef struct packed {
    logic [1:0]  cmd_lanes;
    logic [1:0]  addr_lanes;
    logic [1:0]  data_lanes;
    logic [1:0]  addr_bytes;
    logic [3:0]  dummy;
    logic        is_write;
    logic        mode_en;
    logic [7:0]  opcode;
    logic [7:0]  mode_bits;
    logic [31:0] address;
    logic [31:0] length;
  } cmd_cfg_bus_t;

  typedef struct packed {
    logic enable;
    logic xip_en;
    logic quad_en;
    logic cpol;
    logic cpha;
    logic lsb_first;
  } ctrl_bus_t;

  // One-cycle pulses from the engine
  typedef struct packed {
    logic cmd_done_set;
    logic err_set;
  } csr_events_t;

endpackage

//--- src/csr_map_pkg.sv
/*
  Register map of the QSPI control block: index enum, offsets and field layouts.
  Only word-aligned offsets are mapped; any other offset decodes to REG_NONE.
  ID and STATUS are read-only from the bus point of view.
*/
`include "qspi_csr_config.svh"

package csr_map_pkg;

  typedef enum logic [3:0] {
    REG_ID,
    REG_CTRL,
    REG_STATUS,
    REG_INT_EN,
    REG_INT_STAT,
    REG_CMD_CFG,
    REG_CMD_OP,
    REG_CMD_ADDR,
    REG_CMD_LEN,
    REG_NONE
  } csr_reg_e;

  // ----------------------------------------
  // Byte offsets within the window
  localparam logic [`CSR_ADDR_W-1:0] OFF_ID       = 'h000;
  localparam logic [`CSR_ADDR_W-1:0] OFF_CTRL     = 'h004;
  localparam logic [`CSR_ADDR_W-1:0] OFF_STATUS   = 'h008;
  localparam logic [`CSR_ADDR_W-1:0] OFF_INT_EN   = 'h00C;
  localparam logic [`CSR_ADDR_W-1:0] OFF_INT_STAT = 'h010;
  localparam logic [`CSR_ADDR_W-1:0] OFF_CMD_CFG  = 'h024;
  localparam logic [`CSR_ADDR_W-1:0] OFF_CMD_OP   = 'h028;
  localparam logic [`CSR_ADDR_W-1:0] OFF_CMD_ADDR = 'h02C;
  localparam logic [`CSR_ADDR_W-1:0] OFF_CMD_LEN  = 'h030;

  // ----------------------------------------
  // Field layouts
  typedef struct packed {
    logic [22:0] rsvd_hi;
    logic        trigger;
    logic [1:0]  rsvd_lo;
    logic        lsb_first;
    logic        cpha;
    logic        cpol;
    logic        quad_en;
    logic        xip_en;
    logic        enable;
  } ctrl_reg_t;

  typedef struct packed {
    logic [17:0] rsvd;
    logic        mode_en;
    logic        is_write;
    logic [3:0]  dummy_cycles;
    logic [1:0]  addr_bytes;
    logic [1:0]  data_lanes;
    logic [1:0]  addr_lanes;
    logic [1:0]  cmd_lanes;
  } cmd_cfg_t;

  // Shared by INT_EN and INT_STAT
  typedef struct packed {
    logic err;
    logic cmd_done;
  } irq_vec_t;

  function automatic csr_reg_e csr_lookup(input logic [`CSR_ADDR_W-1:0] offset);
    csr_reg_e idx;
    case (offset)
      OFF_ID:       idx = REG_ID;
      OFF_CTRL:     idx = REG_CTRL;
      OFF_STATUS:   idx = REG_STATUS;
      OFF_INT_EN:   idx = REG_INT_EN;
      OFF_INT_STAT: idx = REG_INT_STAT;
      OFF_CMD_CFG:  idx = REG_CMD_CFG;
      OFF_CMD_OP:   idx = REG_CMD_OP;
      OFF_CMD_ADDR: idx = REG_CMD_ADDR;
      OFF_CMD_LEN:  idx = REG_CMD_LEN;
      default:      idx = REG_NONE;
    endcase
    return idx;
  endfunction

  function automatic logic csr_is_ro(input csr_reg_e idx);
    return (idx == REG_ID) || (idx == REG_STATUS);
  endfunction

endpackage

//--- src/qspi_csr_config.svh
/*
  Build-time constants for the QSPI register block.
  The address width covers one 4 KB APB window; only the low bits are decoded.
  Write masks and reset values are full 32-bit words unless noted.
*/
`ifndef QSPI_CSR_CONFIG_SVH
`define QSPI_CSR_CONFIG_SVH

// APB address width
`define CSR_ADDR_W 12

// Constant ID word, read-only
`define CSR_ID_VALUE 32'h1A00_1081

// Writable CTRL bits; the trigger (bit 8) is never stored
`define CSR_CTRL_WMASK 32'h0000_003F
`define CSR_CMD_CFG_WMASK 32'h0000_3FFF

// Reset defaults
`define CSR_CTRL_RESET 32'h0000_0000
`define CSR_CMD_RESET 32'h0000_0000
`define CSR_INT_RESET 2'b00

`endif
